//--- include/soc_bus_macros.svh
`ifndef SOC_BUS_MACROS_SVH
`define SOC_BUS_MACROS_SVH

// system bus address map.

// sram window, both bounds inclusive.
`define SRAM_BASE       32'h8000_0000
`define SRAM_LAST       32'h87ff_ffff

// memory depth in 32-bit words, a power of two.
`define SRAM_WORDS      1024

// console transmit register.
`define UART_TX_ADDR    32'ha000_03f8

// mtime counter, low word then high word.
`define CLINT_MTIME_LO  32'ha000_0048
`define CLINT_MTIME_HI  32'ha000_004c

`endif

//--- verilog/soc_bus_pkg.sv
package soc_bus_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0]  strb_t;

	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} resp_e;

	// who holds the shared read path.
	typedef enum logic [1:0] {RD_IDLE, RD_IFU, RD_LSU} rd_owner_e;

	typedef enum logic [1:0] {WR_IDLE, WR_BUSY, WR_RESP} wr_state_e;

	typedef enum logic [1:0] {SEL_SRAM, SEL_UART, SEL_CLINT, SEL_NONE} slave_sel_e;

	typedef struct packed {
		addr_t addr;
	} ar_chan_t;

	typedef struct packed {
		data_t data;
		resp_e resp;
	} r_chan_t;

	typedef struct packed {
		addr_t addr;
	} aw_chan_t;

	typedef struct packed {
		data_t data;
		strb_t strb;
	} w_chan_t;

	typedef struct packed {
		resp_e resp;
	} b_chan_t;

endpackage

//--- verilog/xbar.sv
`timescale 1ns/1ps
`include "soc_bus_macros.svh"

module xbar import soc_bus_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,

	input  ar_chan_t ifu_ar,
	input  logic     ifu_arvalid,
	output logic     ifu_arready,
	output r_chan_t  ifu_r,
	output logic     ifu_rvalid,
	input  logic     ifu_rready,

	input  ar_chan_t lsu_ar,
	input  logic     lsu_arvalid,
	output logic     lsu_arready,
	output r_chan_t  lsu_r,
	output logic     lsu_rvalid,
	input  logic     lsu_rready,
	input  aw_chan_t lsu_aw,
	input  logic     lsu_awvalid,
	output logic     lsu_awready,
	input  w_chan_t  lsu_w,
	input  logic     lsu_wvalid,
	output logic     lsu_wready,
	output b_chan_t  lsu_b,
	output logic     lsu_bvalid,
	input  logic     lsu_bready,

	output ar_chan_t sram_ar,
	output logic     sram_arvalid,
	input  logic     sram_arready,
	input  r_chan_t  sram_r,
	input  logic     sram_rvalid,
	output logic     sram_rready,
	output aw_chan_t sram_aw,
	output logic     sram_awvalid,
	input  logic     sram_awready,
	output w_chan_t  sram_w,
	output logic     sram_wvalid,
	input  logic     sram_wready,
	input  b_chan_t  sram_b,
	input  logic     sram_bvalid,
	output logic     sram_bready,

	output aw_chan_t uart_aw,
	output logic     uart_awvalid,
	input  logic     uart_awready,
	output w_chan_t  uart_w,
	output logic     uart_wvalid,
	input  logic     uart_wready,
	input  b_chan_t  uart_b,
	input  logic     uart_bvalid,
	output logic     uart_bready,

	output ar_chan_t clint_ar,
	output logic     clint_arvalid,
	input  logic     clint_arready,
	input  r_chan_t  clint_r,
	input  logic     clint_rvalid,
	output logic     clint_rready
);

	rd_owner_e  rd_owner;
	slave_sel_e rd_sel;
	logic       rd_err_valid; // DECERR read answer pending.
	wr_state_e  wr_state;
	slave_sel_e wr_sel;

	ar_chan_t own_ar;
	logic     own_arvalid, own_arready;
	r_chan_t  own_r;
	logic     own_rvalid, own_rready;
	logic     r_fire, wr_fire;
	logic     wr_busy, wr_resp;

	// uart is write only and clint read only.
	function automatic slave_sel_e decode(addr_t a, logic is_wr);
		if (a >= `SRAM_BASE && a <= `SRAM_LAST)
			return SEL_SRAM;
		if (is_wr && a == `UART_TX_ADDR)
			return SEL_UART;
		if (!is_wr && (a == `CLINT_MTIME_LO || a == `CLINT_MTIME_HI))
			return SEL_CLINT;
		return SEL_NONE;
	endfunction

	always_comb begin
		own_ar      = (rd_owner == RD_LSU) ? lsu_ar : ifu_ar;
		own_arvalid = (rd_owner == RD_IFU) ? ifu_arvalid : (rd_owner == RD_LSU) && lsu_arvalid;
		own_rready  = (rd_owner == RD_IFU) ? ifu_rready : (rd_owner == RD_LSU) && lsu_rready;
		case (rd_sel)
			SEL_SRAM: begin
				own_arready = sram_arready;
				own_rvalid  = sram_rvalid;
				own_r       = sram_r;
			end
			SEL_CLINT: begin
				own_arready = clint_arready;
				own_rvalid  = clint_rvalid;
				own_r       = clint_r;
			end
			default: begin // answered here.
				own_arready = !rd_err_valid;
				own_rvalid  = rd_err_valid;
				own_r       = '{data: '0, resp: DECERR};
			end
		endcase
	end

	assign sram_ar       = own_ar;
	assign clint_ar      = own_ar;
	assign sram_arvalid  = own_arvalid && rd_sel == SEL_SRAM;
	assign clint_arvalid = own_arvalid && rd_sel == SEL_CLINT;
	assign sram_rready   = own_rready && rd_sel == SEL_SRAM;
	assign clint_rready  = own_rready && rd_sel == SEL_CLINT;

	assign ifu_arready = rd_owner == RD_IFU && own_arready;
	assign lsu_arready = rd_owner == RD_LSU && own_arready;
	assign ifu_rvalid  = rd_owner == RD_IFU && own_rvalid;
	assign lsu_rvalid  = rd_owner == RD_LSU && own_rvalid;
	assign ifu_r       = (rd_owner == RD_IFU) ? own_r : '0;
	assign lsu_r       = (rd_owner == RD_LSU) ? own_r : '0;
	assign r_fire      = own_rvalid && own_rready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_owner     <= RD_IDLE;
			rd_sel       <= SEL_NONE;
			rd_err_valid <= 1'b0;
		end else begin
			case (rd_owner)
				RD_IDLE: begin
					if (ifu_arvalid) begin // ifu wins ties.
						rd_owner <= RD_IFU;
						rd_sel   <= decode(ifu_ar.addr, 1'b0);
					end else if (lsu_arvalid) begin
						rd_owner <= RD_LSU;
						rd_sel   <= decode(lsu_ar.addr, 1'b0);
					end
				end
				default: if (r_fire) rd_owner <= RD_IDLE;
			endcase
			if (own_arvalid && own_arready && rd_sel == SEL_NONE)
				rd_err_valid <= 1'b1;
			else if (r_fire)
				rd_err_valid <= 1'b0;
		end
	end

	assign wr_busy = wr_state == WR_BUSY;
	assign wr_resp = wr_state == WR_RESP;

	assign sram_aw      = lsu_aw;
	assign uart_aw      = lsu_aw;
	assign sram_w       = lsu_w;
	assign uart_w       = lsu_w;
	assign sram_awvalid = wr_busy && wr_sel == SEL_SRAM && lsu_awvalid;
	assign sram_wvalid  = wr_busy && wr_sel == SEL_SRAM && lsu_wvalid;
	assign uart_awvalid = wr_busy && wr_sel == SEL_UART && lsu_awvalid;
	assign uart_wvalid  = wr_busy && wr_sel == SEL_UART && lsu_wvalid;
	assign sram_bready  = wr_resp && wr_sel == SEL_SRAM && lsu_bready;
	assign uart_bready  = wr_resp && wr_sel == SEL_UART && lsu_bready;

	always_comb begin
		case (wr_sel)
			SEL_SRAM: begin
				lsu_awready = wr_busy && sram_awready;
				lsu_wready  = wr_busy && sram_wready;
				lsu_bvalid  = wr_resp && sram_bvalid;
				lsu_b       = sram_b;
			end
			SEL_UART: begin
				lsu_awready = wr_busy && uart_awready;
				lsu_wready  = wr_busy && uart_wready;
				lsu_bvalid  = wr_resp && uart_bvalid;
				lsu_b       = uart_b;
			end
			default: begin
				lsu_awready = wr_busy;
				lsu_wready  = wr_busy;
				lsu_bvalid  = wr_resp; // one cycle after acceptance.
				lsu_b       = '{resp: DECERR};
			end
		endcase
	end

	assign wr_fire = lsu_awvalid && lsu_awready && lsu_wvalid && lsu_wready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_state <= WR_IDLE;
			wr_sel   <= SEL_NONE;
		end else begin
			case (wr_state)
				WR_IDLE: begin
					if (lsu_awvalid) begin
						wr_state <= WR_BUSY;
						wr_sel   <= decode(lsu_aw.addr, 1'b1);
					end
				end
				WR_BUSY: if (wr_fire) wr_state <= WR_RESP;
				default: if (lsu_bvalid && lsu_bready) wr_state <= WR_IDLE;
			endcase
		end
	end

	// once ifu has its address through, lsu waits for the ifu data.
	a_rd_excl: assert property (@(posedge clk) disable iff (!rst_n)
		ifu_arvalid && ifu_arready |=> !lsu_arready until_with (ifu_rvalid && ifu_rready));

	a_lsu_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
		lsu_rvalid && !lsu_rready |=> lsu_rvalid && $stable(lsu_r));

endmodule

//--- verilog/axi_sram.sv
`timescale 1ns/1ps
`include "soc_bus_macros.svh"

module axi_sram import soc_bus_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,

	input  ar_chan_t ar,
	input  logic     arvalid,
	output logic     arready,
	output r_chan_t  r,
	output logic     rvalid,
	input  logic     rready,

	input  aw_chan_t aw,
	input  logic     awvalid,
	output logic     awready,
	input  w_chan_t  w,
	input  logic     wvalid,
	output logic     wready,
	output b_chan_t  b,
	output logic     bvalid,
	input  logic     bready
);

	localparam int IDX_W = $clog2(`SRAM_WORDS);

	data_t            mem [`SRAM_WORDS];
	data_t            rdata_q;
	logic [IDX_W-1:0] rd_idx;
	logic [IDX_W-1:0] wr_idx;
	logic             rd_fire;
	logic             wr_fire;

	// one response at a time per channel.
	assign arready = !rvalid;
	assign awready = !bvalid;
	assign wready  = !bvalid;

	assign rd_fire = arvalid && arready;
	assign wr_fire = awvalid && awready && wvalid && wready;

	// word index, upper address bits alias.
	assign rd_idx = ar.addr[IDX_W+1:2];
	assign wr_idx = aw.addr[IDX_W+1:2];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rvalid <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			if (rd_fire)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;

			if (wr_fire)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_fire)
			rdata_q <= mem[rd_idx]; // old word on a same-cycle write.
		if (wr_fire) begin
			for (int i = 0; i < 4; i++) begin
				if (w.strb[i])
					mem[wr_idx][8*i +: 8] <= w.data[8*i +: 8];
			end
		end
	end

	assign r = '{data: rdata_q, resp: OKAY};
	assign b = '{resp: OKAY};

	// a pending read request stays up with the same address until taken.
	a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
		arvalid && !arready |=> arvalid && $stable(ar));

endmodule

//--- verilog/axi_uart_tx.sv
`timescale 1ns/1ps

module axi_uart_tx import soc_bus_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,

	input  aw_chan_t   aw,
	input  logic       awvalid,
	output logic       awready,
	input  w_chan_t    w,
	input  logic       wvalid,
	output logic       wready,
	output b_chan_t    b,
	output logic       bvalid,
	input  logic       bready,

	output logic [7:0] tx_data,
	output logic       tx_valid
);

	logic wr_fire;

	assign awready = !bvalid;
	assign wready  = !bvalid;
	assign wr_fire = awvalid && awready && wvalid && wready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bvalid   <= 1'b0;
			tx_valid <= 1'b0;
		end else begin
			tx_valid <= wr_fire && w.strb[0]; // single cycle pulse.
			if (wr_fire)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
		end
	end

	// console byte sits in lane 0.
	always_ff @(posedge clk) begin
		if (wr_fire && w.strb[0])
			tx_data <= w.data[7:0];
	end

	// nothing to refuse, writes without the strobe are simply dropped.
	assign b = '{resp: OKAY};

endmodule

//--- verilog/axi_clint.sv
`timescale 1ns/1ps

module axi_clint import soc_bus_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,

	input  ar_chan_t ar,
	input  logic     arvalid,
	output logic     arready,
	output r_chan_t  r,
	output logic     rvalid,
	input  logic     rready
);

	logic [63:0] mtime;
	data_t       rdata_q;
	logic        rd_fire;

	assign arready = !rvalid;
	assign rd_fire = arvalid && arready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mtime  <= '0;
			rvalid <= 1'b0;
		end else begin
			mtime <= mtime + 64'd1;
			if (rd_fire)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	// bit 2 picks the high word.
	always_ff @(posedge clk) begin
		if (rd_fire)
			rdata_q <= ar.addr[2] ? mtime[63:32] : mtime[31:0];
	end

	assign r = '{data: rdata_q, resp: OKAY};

endmodule

//--- verilog/soc_bus_top.sv
`timescale 1ns/1ps

module soc_bus_top import soc_bus_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,

	input  ar_chan_t   ifu_ar,
	input  logic       ifu_arvalid,
	output logic       ifu_arready,
	output r_chan_t    ifu_r,
	output logic       ifu_rvalid,
	input  logic       ifu_rready,

	input  ar_chan_t   lsu_ar,
	input  logic       lsu_arvalid,
	output logic       lsu_arready,
	output r_chan_t    lsu_r,
	output logic       lsu_rvalid,
	input  logic       lsu_rready,
	input  aw_chan_t   lsu_aw,
	input  logic       lsu_awvalid,
	output logic       lsu_awready,
	input  w_chan_t    lsu_w,
	input  logic       lsu_wvalid,
	output logic       lsu_wready,
	output b_chan_t    lsu_b,
	output logic       lsu_bvalid,
	input  logic       lsu_bready,

	output logic [7:0] tx_data,
	output logic       tx_valid
);

	ar_chan_t sram_ar, clint_ar;
	r_chan_t  sram_r, clint_r;
	aw_chan_t sram_aw, uart_aw;
	w_chan_t  sram_w, uart_w;
	b_chan_t  sram_b, uart_b;
	logic     sram_arvalid, sram_arready, sram_rvalid, sram_rready;
	logic     sram_awvalid, sram_awready, sram_wvalid, sram_wready;
	logic     sram_bvalid, sram_bready;
	logic     uart_awvalid, uart_awready, uart_wvalid, uart_wready;
	logic     uart_bvalid, uart_bready;
	logic     clint_arvalid, clint_arready, clint_rvalid, clint_rready;

	xbar u_xbar (.*);

	axi_sram u_sram (
		.clk, .rst_n,
		.ar(sram_ar), .arvalid(sram_arvalid), .arready(sram_arready),
		.r(sram_r), .rvalid(sram_rvalid), .rready(sram_rready),
		.aw(sram_aw), .awvalid(sram_awvalid), .awready(sram_awready),
		.w(sram_w), .wvalid(sram_wvalid), .wready(sram_wready),
		.b(sram_b), .bvalid(sram_bvalid), .bready(sram_bready)
	);

	axi_uart_tx u_uart (
		.clk, .rst_n,
		.aw(uart_aw), .awvalid(uart_awvalid), .awready(uart_awready),
		.w(uart_w), .wvalid(uart_wvalid), .wready(uart_wready),
		.b(uart_b), .bvalid(uart_bvalid), .bready(uart_bready),
		.tx_data, .tx_valid
	);

	axi_clint u_clint (
		.clk, .rst_n,
		.ar(clint_ar), .arvalid(clint_arvalid), .arready(clint_arready),
		.r(clint_r), .rvalid(clint_rvalid), .rready(clint_rready)
	);

endmodule

//--- verification/soc_bus_tb.sv
`timescale 1ns/1ps

module soc_bus_tb import soc_bus_pkg::*; ();

	logic       clk, rst_n;
	ar_chan_t   ifu_ar, lsu_ar;
	logic       ifu_arvalid, ifu_arready, ifu_rvalid, ifu_rready;
	r_chan_t    ifu_r, lsu_r;
	logic       lsu_arvalid, lsu_arready, lsu_rvalid, lsu_rready;
	aw_chan_t   lsu_aw;
	w_chan_t    lsu_w;
	b_chan_t    lsu_b;
	logic       lsu_awvalid, lsu_awready, lsu_wvalid, lsu_wready, lsu_bvalid, lsu_bready;
	logic [7:0] tx_data;
	logic       tx_valid;

	byte         t_op[$];
	logic [31:0] t_addr[$], t_data[$], t_exp[$];
	logic [3:0]  t_strb[$];
	logic [1:0]  t_resp[$];

	int          test_count = 0;
	int          err_count = 0;
	int          fail_count = 0;
	int          tx_count = 0;
	logic [7:0]  tx_last;
	logic [31:0] last_rd = '0;
	bit          started = 1'b0;

	soc_bus_top u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// console bytes as they leave the top level.
	always @(posedge clk) begin
		if (rst_n && tx_valid) begin
			tx_count <= tx_count + 1;
			tx_last  <= tx_data;
		end
	end

	task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
		if (act !== exp) begin
			$display("** Error: %s is 0x%h, expected 0x%h", name, act, exp);
			err_count++;
		end
	endtask

	task automatic load_tests(output int count);
		int          fd;
		int          code;
		string       line;
		byte         op;
		logic [31:0] a, d, e;
		logic [3:0]  s;
		logic [1:0]  rs;
		count = 0;
		fd = $fopen("verification/soc_bus_testdata.txt", "r");
		if (fd == 0)
			return;
		while (!$feof(fd)) begin
			code = $fgets(line, fd);
			if (code > 0 && $sscanf(line, "%c %h %h %h %h %h", op, a, d, s, rs, e) == 6 &&
					(op == "F" || op == "R" || op == "W" || op == "P")) begin
				t_op.push_back(op);
				t_addr.push_back(a);
				t_data.push_back(d);
				t_strb.push_back(s);
				t_resp.push_back(rs);
				t_exp.push_back(e);
				count++;
			end
		end
		$fclose(fd);
	endtask

	// rready stays low for the first stall cycles.
	task automatic read_txn(input bit lsu, input logic [31:0] addr, input int stall,
			output r_chan_t r, output int edges, output time done_t);
		int n;
		bit ar_done;
		bit r_done;
		n = 0;
		ar_done = 1'b0;
		r_done = 1'b0;
		edges = 0;
		@(negedge clk);
		if (lsu) begin
			lsu_ar.addr = addr;
			lsu_arvalid = 1'b1;
			lsu_rready  = stall == 0;
		end else begin
			ifu_ar.addr = addr;
			ifu_arvalid = 1'b1;
			ifu_rready  = stall == 0;
		end
		while (!r_done) begin
			@(posedge clk);
			edges++;
			if (lsu ? lsu_arready : ifu_arready)
				ar_done = 1'b1;
			if (lsu ? (lsu_rvalid && lsu_rready) : (ifu_rvalid && ifu_rready)) begin
				r = lsu ? lsu_r : ifu_r;
				r_done = 1'b1;
				done_t = $time;
			end
			@(negedge clk);
			n++;
			if (lsu) begin
				lsu_arvalid = lsu_arvalid && !ar_done;
				lsu_rready  = !r_done && n >= stall;
			end else begin
				ifu_arvalid = ifu_arvalid && !ar_done;
				ifu_rready  = !r_done && n >= stall;
			end
		end
	endtask

	task automatic write_txn(input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] strb, input int stall, output b_chan_t b);
		int n;
		bit aw_done;
		bit b_done;
		n = 0;
		aw_done = 1'b0;
		b_done = 1'b0;
		@(negedge clk);
		lsu_aw.addr = addr;
		lsu_w.data  = data;
		lsu_w.strb  = strb;
		lsu_awvalid = 1'b1;
		lsu_wvalid  = 1'b1;
		lsu_bready  = stall == 0;
		while (!b_done) begin
			@(posedge clk);
			if (lsu_awready && lsu_wready)
				aw_done = 1'b1;
			if (lsu_bvalid && lsu_bready) begin
				b = lsu_b;
				b_done = 1'b1;
			end
			@(negedge clk);
			n++;
			lsu_awvalid = lsu_awvalid && !aw_done;
			lsu_wvalid  = lsu_awvalid;
			lsu_bready  = !b_done && n >= stall;
		end
	endtask

	task automatic run_test(input int idx);
		byte     op;
		r_chan_t r_ifu, r_lsu;
		b_chan_t b;
		int      edges, edges_lsu, pulses, errs_before;
		time     t_ifu, t_lsu;
		op = t_op[idx];
		errs_before = err_count;
		case (op)
			"W": begin
				pulses = tx_count;
				write_txn(t_addr[idx], t_data[idx], t_strb[idx], $urandom % 4, b);
				@(posedge clk); // a late pulse would show up here.
				@(negedge clk);
				check("lsu_b.resp", b.resp, t_resp[idx]);
				check("tx_valid pulses", tx_count - pulses, t_exp[idx][8]);
				if (t_exp[idx][8])
					check("tx_data", tx_last, t_exp[idx][7:0]);
			end
			"P": begin
				fork
					read_txn(1'b0, t_addr[idx], $urandom % 4, r_ifu, edges, t_ifu);
					read_txn(1'b1, t_addr[idx], $urandom % 4, r_lsu, edges_lsu, t_lsu);
				join
				check("ifu_r.resp", r_ifu.resp, t_resp[idx]);
				check("ifu_r.data", r_ifu.data, t_exp[idx]);
				check("lsu_r.resp", r_lsu.resp, t_resp[idx]);
				check("lsu_r.data", r_lsu.data, t_exp[idx]);
				if (!(t_ifu < t_lsu)) begin
					$display("ifu read did not finish before the competing lsu read");
					err_count++;
				end
			end
			default: begin
				read_txn(op == "R", t_addr[idx], (op == "R") ? $urandom % 4 : 0, r_ifu,
					edges, t_ifu);
				check(op == "R" ? "lsu_r.resp" : "ifu_r.resp", r_ifu.resp, t_resp[idx]);
				if (t_strb[idx] == 4'd0)
					check(op == "R" ? "lsu_r.data" : "ifu_r.data", r_ifu.data, t_exp[idx]);
				else if (t_strb[idx] == 4'd2 && !(r_ifu.data > last_rd)) begin
					$display("read value 0x%h did not rise above 0x%h", r_ifu.data, last_rd);
					err_count++;
				end
				last_rd = r_ifu.data;
				if (op == "F")
					check("ifu r latency", edges, 3); // edges from arvalid to r transfer.
			end
		endcase
		if (err_count != errs_before)
			fail_count++;
		$display("test %0d: %c 0x%h %s", idx, op, t_addr[idx],
			(err_count == errs_before) ? "ok" : "FAILED");
	endtask

	initial begin
		wait (started);
		repeat (test_count * 40 + 100) @(posedge clk);
		$display("timeout, the bus stopped answering before all tests finished");
		$display("Some tests failed");
		$finish;
	end

	initial begin
		int unsigned seed_val;
		rst_n       = 1'b0;
		ifu_ar      = '0;
		ifu_arvalid = 1'b0;
		ifu_rready  = 1'b0;
		lsu_ar      = '0;
		lsu_arvalid = 1'b0;
		lsu_rready  = 1'b0;
		lsu_aw      = '0;
		lsu_awvalid = 1'b0;
		lsu_w       = '0;
		lsu_wvalid  = 1'b0;
		lsu_bready  = 1'b0;
		seed_val = $urandom(32'had7e5a0e);
		load_tests(test_count);
		if (test_count == 0) begin
			$display("no test lines could be read from the data file");
			$display("Some tests failed");
		end else begin
			started = 1'b1;
			repeat (2) @(posedge clk);
			@(negedge clk);
			rst_n = 1'b1;
			for (int i = 0; i < test_count; i++)
				run_test(i);
			$display("%0d tests run, %0d failed, %0d check errors",
				test_count, fail_count, err_count);
			if (err_count == 0)
				$display("All tests passed");
			else
				$display("Some tests failed");
		end
		$finish;
	end

endmodule

//--- project.f
+incdir+include
verilog/soc_bus_pkg.sv
verilog/xbar.sv
verilog/axi_sram.sv
verilog/axi_uart_tx.sv
verilog/axi_clint.sv
verilog/soc_bus_top.sv
verification/soc_bus_tb.sv

//--- verification/soc_bus_testdata.txt
# op: F ifu read, R lsu read, W lsu write, P ifu and lsu read in the same cycle.
# columns: op addr data strb resp exp_data, all hex. on reads strb picks the data check
# (0 exact, 1 record only, 2 above the last read); on writes exp_data[8] marks a tx byte.
W 80000000 11223344 f 0 00000000
R 80000000 00000000 0 0 11223344
W 80000000 aabbccdd 5 0 00000000
F 80000000 00000000 0 0 11bb33dd
W 80000004 cafef00d f 0 00000000
W 80000004 12345678 a 0 00000000
R 80000004 00000000 0 0 12fe560d
W a00003f8 00000041 1 0 00000141
W a00003f8 00000042 e 0 00000000
W a00003f8 0000005a f 0 0000015a
W 90000000 deadbeef f 3 00000000
W a0000048 ffffffff f 3 00000000
R 80000000 00000000 0 0 11bb33dd
F 10000000 00000000 0 3 00000000
R a00003f8 00000000 0 3 00000000
P 80000004 00000000 0 0 12fe560d
P 80000000 00000000 0 0 11bb33dd
R a0000048 00000000 1 0 00000000
R a0000048 00000000 2 0 00000000
R a000004c 00000000 0 0 00000000
F 80000004 00000000 0 0 12fe560d
